// File: hw/conv_pkg.sv
// conv_pkg holds the datapath widths, tap count and RAM layout of the convolution core
`default_nettype none

package conv_pkg;

    // operands and products
    localparam int unsigned TAPS   = 27;              // one 3x3x3 window
    localparam int unsigned PIX_W  = 8;
    localparam int unsigned WGT_W  = 8;
    localparam int unsigned PROD_W = PIX_W + WGT_W;   // 16
    localparam int unsigned SUM_W  = PROD_W + 5;      // five tree levels for 27 inputs

    // shared RAM geometry, one byte per word
    localparam int unsigned RAM_DEPTH = 64;
    localparam int unsigned RAM_DW    = 8;
    localparam int unsigned RAM_AW    = $clog2(RAM_DEPTH);
    localparam int unsigned PIX_BASE  = 0;            // pixels in the low half
    localparam int unsigned WGT_BASE  = 32;           // weights in the high half

    // pipeline latencies seen by the sequencer
    localparam int unsigned TREE_STAGES = $clog2(TAPS);
    localparam int unsigned MUL_LAT     = 1;

endpackage

`default_nettype wire

// File: hw/csr_pkg.sv
// csr_pkg defines the APB address map and the register bit positions of the accelerator
`default_nettype none

package csr_pkg;

    localparam int unsigned APB_AW = 12;
    localparam int unsigned APB_DW = 32;

    // register offsets
    localparam logic [APB_AW-1:0] CTRL_OFS   = 12'h000;
    localparam logic [APB_AW-1:0] STATUS_OFS = 12'h004;
    localparam logic [APB_AW-1:0] RESULT_OFS = 12'h008;

    // RAM window, word i sits at RAM_WIN_BASE + 4*i
    localparam int unsigned       RAM_WIN_WORDS = 64;
    localparam logic [APB_AW-1:0] RAM_WIN_BASE  = 12'h100;
    localparam logic [APB_AW-1:0] RAM_WIN_END   = 12'h200;  // first address past the window

    // CTRL bits
    localparam int unsigned CTRL_START_BIT = 0;

    // STATUS bits
    localparam int unsigned STAT_BUSY_BIT = 0;
    localparam int unsigned STAT_DONE_BIT = 1;

endpackage

`default_nettype wire

// File: hw/ram_port_if.sv
// ram_port_if bundles one requester's access to the shared RAM arbiter
`timescale 1ns/1ps
`default_nettype none

interface ram_port_if
    import conv_pkg::*;
();

    logic              req;    // held with we/addr/wdata until gnt
    logic              we;
    logic [RAM_AW-1:0] addr;
    logic [RAM_DW-1:0] wdata;
    logic              gnt;    // combinational, one cycle
    logic [RAM_DW-1:0] rdata;  // valid the cycle after a read grant

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

// File: hw/add_tree_unsigned.sv
// add_tree_unsigned sums a row of unsigned words through a registered binary tree
`timescale 1ns/1ps
`default_nettype none

module add_tree_unsigned #(
    parameter int unsigned INPUTS_NUM  = 27,
    parameter int unsigned IDATA_WIDTH = 16
)(
    input  wire                                   sclk,
    input  wire                                   s_rst_n,
    input  wire  [INPUTS_NUM*IDATA_WIDTH-1:0]     idata,
    output logic [IDATA_WIDTH+$clog2(INPUTS_NUM)-1:0] data_out
);

    localparam int unsigned STAGES_NUM     = $clog2(INPUTS_NUM);
    localparam int unsigned INPUTS_NUM_INT = 2 ** STAGES_NUM;  // padded to a power of two

    genvar s, a;

    for (s = 0; s <= STAGES_NUM; s++) begin : g_lvl
        localparam int unsigned N = INPUTS_NUM_INT >> s;
        localparam int unsigned W = IDATA_WIDTH + s;     // one extra bit per level

        logic [W-1:0] node [N];

        if (s == 0) begin : g_in
            // level 0 is the input row itself, no register here
            for (a = 0; a < N; a++) begin : g_pad
                if (a < INPUTS_NUM) begin : g_tap
                    assign node[a] = idata[a*IDATA_WIDTH +: IDATA_WIDTH];
                end else begin : g_zero
                    assign node[a] = '0;                 // padding taps
                end
            end
        end else begin : g_add
            always_ff @(posedge sclk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                    for (int i = 0; i < N; i++) begin
                        node[i] <= '0;
                    end
                end else begin
                    for (int i = 0; i < N; i++) begin
                        // carry lands in the new top bit
                        node[i] <= g_lvl[s-1].node[2*i] + g_lvl[s-1].node[2*i+1];
                    end
                end
            end
        end
    end

    assign data_out = g_lvl[STAGES_NUM].node[0];  // root of the tree

endmodule

`default_nettype wire

// File: hw/mul_array.sv
// mul_array forms the registered unsigned pixel times weight product of every tap
`timescale 1ns/1ps
`default_nettype none

module mul_array
    import conv_pkg::*;
#(
    parameter int unsigned TAPS = conv_pkg::TAPS
)(
    input  wire                       sclk,
    input  wire                       s_rst_n,
    input  wire                       op_valid,
    input  wire  [TAPS*PIX_W-1:0]     pix,
    input  wire  [TAPS*WGT_W-1:0]     wgt,
    output logic [TAPS*PROD_W-1:0]    prod
);

    // products only move on op_valid so the tree sees a quiet input between jobs
    always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
            prod <= '0;
        end else if (op_valid) begin
            for (int t = 0; t < TAPS; t++) begin
                prod[t*PROD_W +: PROD_W] <= pix[t*PIX_W +: PIX_W] * wgt[t*WGT_W +: WGT_W];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/shared_ram.sv
// shared_ram is a single-port byte RAM behind a two-port round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module shared_ram
    import conv_pkg::*;
#(
    parameter int unsigned RAM_DEPTH = conv_pkg::RAM_DEPTH
)(
    input  wire           sclk,
    input  wire           s_rst_n,
    ram_port_if.arbiter   host,     // port 0, APB side
    ram_port_if.arbiter   eng       // port 1, sequencer
);

    logic [RAM_DW-1:0] mem [RAM_DEPTH];

    logic              prio;        // 0 favours host, 1 favours eng
    logic              any_gnt;
    logic              acc_we;
    logic [RAM_AW-1:0] acc_addr;
    logic [RAM_DW-1:0] acc_wdata;
    logic [RAM_DW-1:0] rd_q;

    // a lone requester always wins, a tie goes to the pointer
    assign host.gnt = host.req & (~eng.req | ~prio);
    assign eng.gnt  = eng.req & (~host.req | prio);
    assign any_gnt  = host.gnt | eng.gnt;

    // steer the winner onto the single RAM port
    assign acc_we    = eng.gnt ? eng.we    : host.we;
    assign acc_addr  = eng.gnt ? eng.addr  : host.addr;
    assign acc_wdata = eng.gnt ? eng.wdata : host.wdata;

    // pointer moves to the other port after every grant
    always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
            prio <= 1'b0;
        end else if (host.gnt) begin
            prio <= 1'b1;
        end else if (eng.gnt) begin
            prio <= 1'b0;
        end
    end

    always_ff @(posedge sclk) begin
        if (any_gnt) begin
            if (acc_we) begin
                mem[acc_addr] <= acc_wdata;
            end else begin
                rd_q <= mem[acc_addr];
            end
        end
    end

    // only the port granted last cycle samples this
    assign host.rdata = rd_q;
    assign eng.rdata  = rd_q;

endmodule

`default_nettype wire

// File: hw/apb_csr.sv
// apb_csr decodes APB accesses into control, status, result and RAM window traffic
`timescale 1ns/1ps
`default_nettype none

module apb_csr
    import conv_pkg::*;
    import csr_pkg::*;
(
    input  wire                sclk,
    input  wire                s_rst_n,
    input  wire                psel,
    input  wire                penable,
    input  wire                pwrite,
    input  wire  [APB_AW-1:0]  paddr,
    input  wire  [APB_DW-1:0]  pwdata,
    output logic [APB_DW-1:0]  prdata,
    output logic               pready,
    output logic               pslverr,
    ram_port_if.requester      ram,
    output logic               start,
    input  wire                busy,
    input  wire                done,
    input  wire  [SUM_W-1:0]   result
);

    typedef enum logic [1:0] {
        S_IDLE,   // waiting for an access, request raised from here
        S_RDAT,   // RAM read data on ram.rdata this cycle
        S_ACK     // RAM access done, pready high
    } ram_state_t;

    ram_state_t        state;
    logic              access;
    logic              ctrl_hit;
    logic              stat_hit;
    logic              res_hit;
    logic              win_hit;
    logic              unmapped;
    logic [RAM_DW-1:0] rd_q;
    logic [APB_DW-1:0] reg_rdata;

    assign access   = psel & penable;
    assign ctrl_hit = (paddr == CTRL_OFS);
    assign stat_hit = (paddr == STATUS_OFS);
    assign res_hit  = (paddr == RESULT_OFS);
    assign win_hit  = (paddr >= RAM_WIN_BASE) && (paddr < RAM_WIN_END) && (paddr[1:0] == 2'b00);
    assign unmapped = ~(ctrl_hit | stat_hit | res_hit | win_hit);

    // APB holds the address phase, so the request stays steady until the grant
    assign ram.req   = access & win_hit & (state == S_IDLE);
    assign ram.we    = pwrite;
    assign ram.addr  = paddr[RAM_AW+1:2];    // byte offset to word index
    assign ram.wdata = pwdata[RAM_DW-1:0];

    assign start = access & ctrl_hit & pwrite & pwdata[CTRL_START_BIT] & ~busy;

    // registers and unmapped addresses finish in the first access cycle
    assign pready  = (state == S_ACK) | (access & ~win_hit);
    assign pslverr = access & unmapped;

    always_comb begin
        reg_rdata = '0;
        if (stat_hit) begin
            reg_rdata[STAT_BUSY_BIT] = busy;
            reg_rdata[STAT_DONE_BIT] = done;
        end else if (res_hit) begin
            reg_rdata[SUM_W-1:0] = result;
        end
    end

    assign prdata = win_hit ? APB_DW'(rd_q) : reg_rdata;

    always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (ram.gnt) state <= pwrite ? S_ACK : S_RDAT;
                S_RDAT:  state <= S_ACK;
                default: state <= S_IDLE;   // S_ACK closes the transfer
            endcase
        end
    end

    always_ff @(posedge sclk) begin
        if (state == S_RDAT) begin
            rd_q <= ram.rdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/conv_engine.sv
// conv_engine fetches a job's operands from RAM, fires the datapath and captures the sum
`timescale 1ns/1ps
`default_nettype none

module conv_engine
    import conv_pkg::*;
#(
    parameter int unsigned TAPS      = conv_pkg::TAPS,
    parameter int unsigned RAM_DEPTH = conv_pkg::RAM_DEPTH
)(
    input  wire                    sclk,
    input  wire                    s_rst_n,
    input  wire                    start,
    output logic                   busy,
    output logic                   done,
    output logic [SUM_W-1:0]       result,
    ram_port_if.requester          ram,
    output logic                   op_valid,
    output logic [TAPS*PIX_W-1:0]  pix,
    output logic [TAPS*WGT_W-1:0]  wgt,
    input  wire  [SUM_W-1:0]       sum
);

    localparam int unsigned IDX_W   = $clog2(2*TAPS);
    localparam int unsigned LAT     = MUL_LAT + TREE_STAGES;
    localparam int unsigned CNT_W   = $clog2(LAT + 1);

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_LAST, S_FIRE, S_DRAIN} eng_state_t;

    eng_state_t       state;
    logic [IDX_W-1:0] idx;         // operand being requested
    logic [IDX_W-1:0] rd_idx;      // operand whose byte arrives next cycle
    logic             rd_pend;
    logic [CNT_W-1:0] lat_cnt;
    logic [31:0]      fetch_word;

    // pixels first, then weights
    always_comb begin
        if (idx < IDX_W'(TAPS)) begin
            fetch_word = PIX_BASE + idx;
        end else begin
            fetch_word = WGT_BASE + idx - TAPS;
        end
    end

    assign ram.req   = (state == S_FETCH);
    assign ram.we    = 1'b0;                        // read only
    assign ram.addr  = RAM_AW'(fetch_word % RAM_DEPTH);
    assign ram.wdata = '0;
    assign op_valid  = (state == S_FIRE);

    always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
            state   <= S_IDLE;
            idx     <= '0;
            rd_pend <= 1'b0;
            lat_cnt <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
            result  <= '0;
        end else begin
            rd_pend <= ram.gnt;
            case (state)
                S_IDLE: if (start) begin
                    busy  <= 1'b1;
                    done  <= 1'b0;
                    idx   <= '0;
                    state <= S_FETCH;
                end
                S_FETCH: if (ram.gnt) begin
                    if (idx == IDX_W'(2*TAPS - 1)) state <= S_LAST;
                    else idx <= idx + 1'b1;
                end
                S_LAST: state <= S_FIRE;            // last weight lands this cycle
                S_FIRE: begin
                    lat_cnt <= CNT_W'(1);
                    state   <= S_DRAIN;
                end
                default: begin                      // S_DRAIN
                    if (lat_cnt == CNT_W'(LAT)) begin
                        result <= sum;
                        busy   <= 1'b0;
                        done   <= 1'b1;
                        state  <= S_IDLE;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // operand registers
    always_ff @(posedge sclk) begin
        if (ram.gnt) rd_idx <= idx;
        if (rd_pend) begin
            for (int t = 0; t < TAPS; t++) begin
                if (rd_idx == IDX_W'(t)) pix[t*PIX_W +: PIX_W] <= ram.rdata;
                if (rd_idx == IDX_W'(t + TAPS)) wgt[t*WGT_W +: WGT_W] <= ram.rdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/conv_top.sv
// conv_top connects the APB registers, shared RAM, sequencer, multipliers and adder tree
`timescale 1ns/1ps
`default_nettype none

module conv_top
    import conv_pkg::*;
    import csr_pkg::*;
#(
    parameter int unsigned TAPS      = conv_pkg::TAPS,
    parameter int unsigned RAM_DEPTH = conv_pkg::RAM_DEPTH
)(
    input  wire               sclk,
    input  wire               s_rst_n,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  wire  [APB_AW-1:0] paddr,
    input  wire  [APB_DW-1:0] pwdata,
    output wire  [APB_DW-1:0] prdata,
    output wire               pready,
    output wire               pslverr
);

    wire                     start;
    wire                     busy;
    wire                     done;
    wire                     op_valid;
    wire [SUM_W-1:0]         result;
    wire [SUM_W-1:0]         sum;
    wire [TAPS*PIX_W-1:0]    pix;
    wire [TAPS*WGT_W-1:0]    wgt;
    wire [TAPS*PROD_W-1:0]   prod;

    ram_port_if host_port ();   // arbiter port 0
    ram_port_if eng_port ();    // arbiter port 1

    apb_csr u_csr (
        .sclk(sclk), .s_rst_n(s_rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .ram(host_port.requester),
        .start(start), .busy(busy), .done(done), .result(result)
    );

    conv_engine #(.TAPS(TAPS), .RAM_DEPTH(RAM_DEPTH)) u_engine (
        .sclk(sclk), .s_rst_n(s_rst_n),
        .start(start), .busy(busy), .done(done), .result(result),
        .ram(eng_port.requester),
        .op_valid(op_valid), .pix(pix), .wgt(wgt), .sum(sum)
    );

    shared_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
        .sclk(sclk), .s_rst_n(s_rst_n),
        .host(host_port.arbiter), .eng(eng_port.arbiter)
    );

    mul_array #(.TAPS(TAPS)) u_mul (
        .sclk(sclk), .s_rst_n(s_rst_n),
        .op_valid(op_valid), .pix(pix), .wgt(wgt), .prod(prod)
    );

    add_tree_unsigned #(.INPUTS_NUM(TAPS), .IDATA_WIDTH(PROD_W)) u_tree (
        .sclk(sclk), .s_rst_n(s_rst_n),
        .idata(prod), .data_out(sum)
    );

endmodule

`default_nettype wire

// File: verif/conv_assertions.sv
// conv_assertions checks arbiter grants, request hold and APB completion timing
`timescale 1ns/1ps
`default_nettype none

module conv_assertions
    import conv_pkg::*;
#(
    parameter bit ARB_CHECKS = 1'b0,    // instance sits on the arbiter
    parameter bit APB_CHECKS = 1'b0     // instance sits on the APB slave
)(
    input wire              sclk,
    input wire              s_rst_n,
    input wire              gnt_a,      // grants that must never overlap
    input wire              gnt_b,
    input wire              req,        // one requester's port
    input wire              gnt,
    input wire              we,
    input wire [RAM_AW-1:0] addr,
    input wire [RAM_DW-1:0] wdata,
    input wire              psel,
    input wire              penable,
    input wire              pready,
    input wire              pslverr
);

    int unsigned failures = 0;

    if (ARB_CHECKS) begin : g_arb
        a_one_grant: assert property (@(posedge sclk) disable iff (!s_rst_n) !(gnt_a && gnt_b))
            else begin $error("both RAM ports granted in one cycle"); failures++; end
    end

    // a waiting request keeps its command steady
    a_req_hold: assert property (@(posedge sclk) disable iff (!s_rst_n)
        req && !gnt |=> req && $stable(we) && $stable(addr) && $stable(wdata))
        else begin $error("RAM request changed before its grant"); failures++; end

    if (APB_CHECKS) begin : g_apb
        a_apb_phase: assert property (@(posedge sclk) disable iff (!s_rst_n)
            !(psel && penable) |-> !pready && !pslverr)
            else begin $error("pready or pslverr outside an access phase"); failures++; end
    end

endmodule

bind shared_ram conv_assertions #(.ARB_CHECKS(1'b1)) u_arb_sva (
    .sclk(sclk), .s_rst_n(s_rst_n), .gnt_a(host.gnt), .gnt_b(eng.gnt),
    .req(eng.req), .gnt(eng.gnt), .we(eng.we), .addr(eng.addr), .wdata(eng.wdata),
    .psel(1'b0), .penable(1'b0), .pready(1'b0), .pslverr(1'b0)
);

bind apb_csr conv_assertions #(.APB_CHECKS(1'b1)) u_apb_sva (
    .sclk(sclk), .s_rst_n(s_rst_n), .gnt_a(1'b0), .gnt_b(1'b0),
    .req(ram.req), .gnt(ram.gnt), .we(ram.we), .addr(ram.addr), .wdata(ram.wdata),
    .psel(psel), .penable(penable), .pready(pready), .pslverr(pslverr)
);

`default_nettype wire

// File: verif/conv_tb.sv
// conv_tb runs convolution jobs over APB and checks them against a software model of the RAM
`timescale 1ns/1ps
`default_nettype none

module conv_tb
    import conv_pkg::*;
    import csr_pkg::*;
();

    localparam int APB_TIMEOUT  = 40;    // cycles one transfer may wait for pready
    localparam int POLL_TIMEOUT = 100;   // status reads per job

    logic              sclk;
    logic              s_rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    wire  [APB_DW-1:0] prdata;
    wire               pready;
    wire               pslverr;

    logic [RAM_DW-1:0] model [RAM_DEPTH];   // what the RAM should hold
    int                seed = 80770;
    int                errors = 0;
    int                checks = 0;
    int                test_errors = 0;
    string             name_q [$];
    logic [31:0]       got_q [$];
    logic [31:0]       exp_q [$];

    conv_top #(.TAPS(TAPS), .RAM_DEPTH(RAM_DEPTH)) uut (
        .sclk(sclk), .s_rst_n(s_rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        sclk = 1'b0;
        forever #10 sclk = ~sclk;
    end

    // sum of pixel times weight over the model's operand regions
    function automatic logic [31:0] ref_sum();
        logic [31:0] acc;
        acc = '0;
        for (int t = 0; t < TAPS; t++) begin
            acc += 32'(model[PIX_BASE + t]) * 32'(model[WGT_BASE + t]);
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic expect_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    initial begin : compare_proc
        forever begin
            @(posedge sclk);
            while (name_q.size() > 0) begin
                check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    // setup on one falling edge, access on the next, then hold until pready
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata,
                            output logic err);
        int waited;
        waited = 0;
        @(negedge sclk);
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(negedge sclk);
        penable = 1'b1;
        #1;
        while (!pready && waited < APB_TIMEOUT) begin
            @(negedge sclk);
            #1;
            waited++;
        end
        if (!pready) begin
            errors++;
            $display("APB access to 0x%0h never saw pready", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge sclk);                      // transfer closed on the rising edge before
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             output logic err);
        logic [APB_DW-1:0] rd;
        apb_xfer(1'b1, addr, data, rd, err);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    task automatic write_word(input int i, input logic [RAM_DW-1:0] val);
        logic err;
        model[i] = val;
        apb_write(APB_AW'(RAM_WIN_BASE + 4 * i), 32'(val), err);
    endtask

    task automatic load_operands(input bit all_max);
        for (int t = 0; t < TAPS; t++) begin
            write_word(PIX_BASE + t, all_max ? 8'hff : 8'($random(seed)));
            write_word(WGT_BASE + t, all_max ? 8'hff : 8'($random(seed)));
        end
    endtask

    task automatic run_job(input logic [31:0] exp_sum, input int reads, input bit ctrl_poke);
        logic [31:0] rd;
        logic        err;
        int          polls;
        int          a;
        apb_write(CTRL_OFS, 32'h1, err);
        apb_read(STATUS_OFS, rd, err);
        expect_value("status after start", rd, 32'(1) << STAT_BUSY_BIT);  // done cleared
        for (int k = 0; k < reads; k++) begin
            a = int'($unsigned($random(seed)) % RAM_DEPTH);
            apb_read(APB_AW'(RAM_WIN_BASE + 4 * a), rd, err);
            expect_value("ram word during job", rd, 32'(model[a]));
        end
        if (ctrl_poke) begin
            // pixel 0 is already fetched, only a restarted job would see the new byte
            write_word(PIX_BASE, ~model[PIX_BASE]);
            apb_write(CTRL_OFS, 32'h1, err);  // lands while busy
            apb_read(STATUS_OFS, rd, err);
            expect_value("status after busy ctrl", rd, 32'(1) << STAT_BUSY_BIT);
        end
        polls = 0;
        rd    = '0;
        while (!rd[STAT_DONE_BIT] && polls < POLL_TIMEOUT) begin
            apb_read(STATUS_OFS, rd, err);
            polls++;
        end
        if (!rd[STAT_DONE_BIT]) begin
            errors++;
            $display("job did not report done within %0d status reads", POLL_TIMEOUT);
        end
        apb_read(RESULT_OFS, rd, err);
        expect_value("result", rd, exp_sum);
    endtask

    task automatic end_test(input string name);
        int waited;
        waited = 0;
        while (name_q.size() > 0 && waited < 10) begin
            @(negedge sclk);
            waited++;
        end
        if (name_q.size() > 0) begin
            errors++;
            $display("compare process left %0d results unchecked", name_q.size());
        end
        $display("test %s: %s, %0d errors", name, (errors == test_errors) ? "ok" : "FAILED",
                 errors - test_errors);
        test_errors = errors;
    endtask

    initial begin : main_seq
        logic [31:0] rd;
        logic        err;
        int          total;
        s_rst_n = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(posedge sclk);
        @(negedge sclk);
        s_rst_n = 1'b1;

        apb_read(STATUS_OFS, rd, err);
        expect_value("status", rd, 32'h0);
        apb_read(RESULT_OFS, rd, err);
        expect_value("result", rd, 32'h0);
        end_test("reset values");

        for (int i = 0; i < RAM_DEPTH; i++) write_word(i, 8'($random(seed)));
        for (int i = 0; i < RAM_DEPTH; i++) begin
            apb_read(APB_AW'(RAM_WIN_BASE + 4 * i), rd, err);
            expect_value("ram word", rd, 32'(model[i]));
        end
        end_test("ram readback");

        for (int j = 0; j < 4; j++) begin
            load_operands(1'b0);
            run_job(ref_sum(), 0, 1'b0);
        end
        end_test("random jobs");

        load_operands(1'b1);
        run_job(32'd1755675, 0, 1'b0);        // 27 * 255 * 255 fills the tree
        end_test("full scale");

        load_operands(1'b0);
        run_job(ref_sum(), 8, 1'b0);
        end_test("reads during job");

        apb_read(12'h00c, rd, err);
        expect_value("pslverr unmapped read", 32'(err), 32'h1);
        apb_write(12'h0f0, 32'h5a, err);
        expect_value("pslverr unmapped write", 32'(err), 32'h1);
        apb_read(12'h102, rd, err);           // inside the window but not word aligned
        expect_value("pslverr misaligned", 32'(err), 32'h1);
        load_operands(1'b0);
        run_job(ref_sum(), 0, 1'b1);
        end_test("errors and busy ctrl");

        total = errors + int'(uut.u_ram.u_arb_sva.failures)
              + int'(uut.u_csr.u_apb_sva.failures);
        $display("checks: %0d, errors: %0d", checks, total);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hw/conv_pkg.sv
hw/csr_pkg.sv
hw/ram_port_if.sv
hw/add_tree_unsigned.sv
hw/mul_array.sv
hw/shared_ram.sv
hw/apb_csr.sv
hw/conv_engine.sv
hw/conv_top.sv
verif/conv_assertions.sv
verif/conv_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := conv_tb
RTL_TOP    := conv_top
FILE_LIST  := list.f
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
OBJ_DIR    := obj_dir
PASS_MSG   := All tests passed!

SRCS := $(shell cat $(FILE_LIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)
